/* hw/alu_fu.sv */
`include "rs_defines.svh"

module alu_fu (
    input  logic                clock,
    input  logic                reset,
    input  rs_pkg::fu_packet_t  fu_packet,
    input  logic                avail,
    output rs_pkg::cdb_packet_t result
);

    logic [`XLEN-1:0]  alu_out;
    logic              res_valid;
    logic [`PRN_W-1:0] res_prn;
    logic [`XLEN-1:0]  res_value;

    always_comb begin
        case (fu_packet.op)
            rs_pkg::OP_ADD: alu_out = fu_packet.op1 + fu_packet.op2;
            rs_pkg::OP_SUB: alu_out = fu_packet.op1 - fu_packet.op2;
            rs_pkg::OP_AND: alu_out = fu_packet.op1 & fu_packet.op2;
            rs_pkg::OP_OR:  alu_out = fu_packet.op1 | fu_packet.op2;
            rs_pkg::OP_XOR: alu_out = fu_packet.op1 ^ fu_packet.op2;
            default:        alu_out = '0; // Multiplies go to the multiplier
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (avail) begin
            res_valid <= fu_packet.valid;
        end
    end

    // Held while the CDB has not taken the last result
    always_ff @(posedge clock) begin
        if (avail) begin
            res_prn   <= fu_packet.dest_prn;
            res_value <= alu_out;
        end
    end

    assign result = '{valid: res_valid, dest_prn: res_prn, value: res_value};

endmodule

/* hw/cdb_arbiter.sv */
`include "rs_defines.svh"

module cdb_arbiter (
    input  rs_pkg::cdb_packet_t [`NUM_FU_ALU-1:0]  alu_result,
    input  rs_pkg::cdb_packet_t [`NUM_FU_MULT-1:0] mult_result,
    output rs_pkg::cdb_packet_t [`N-1:0]           cdb,
    output logic [`NUM_FU_ALU-1:0]                 fu_alu_avail,
    output logic [`NUM_FU_MULT-1:0]                fu_mult_avail
);

    localparam int UNITS = `NUM_FU_MULT + `NUM_FU_ALU;

    // Index order is priority order, multiplier first
    rs_pkg::cdb_packet_t [UNITS-1:0] results;
    logic [UNITS-1:0]                granted;

    assign results = {alu_result, mult_result};

    always_comb begin
        int slot;
        slot    = 0;
        cdb     = '0;
        granted = '0;
        for (int u = 0; u < UNITS; u++) begin
            if (results[u].valid && slot < `N) begin
                cdb[slot]  = results[u];
                granted[u] = 1'b1;
                slot       = slot + 1;
            end
        end
    end

    // Free next edge if empty or draining now
    always_comb begin
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            fu_mult_avail[m] = !mult_result[m].valid || granted[m];
        end
        for (int a = 0; a < `NUM_FU_ALU; a++) begin
            fu_alu_avail[a] = !alu_result[a].valid || granted[`NUM_FU_MULT + a];
        end
    end

endmodule

/* hw/mult_fu.sv */
`include "rs_defines.svh"

module mult_fu (
    input  logic                clock,
    input  logic                reset,
    input  rs_pkg::fu_packet_t  fu_packet,
    input  logic                avail,
    output rs_pkg::cdb_packet_t result
);

    localparam int LAST = `MULT_STAGES - 1;

    logic [`XLEN-1:0] product;

    logic [`MULT_STAGES-1:0]                  stage_valid;
    logic [`MULT_STAGES-1:0][`PRN_W-1:0]      stage_prn;
    logic [`MULT_STAGES-1:0][`XLEN-1:0]       stage_value;

    assign product = fu_packet.op1 * fu_packet.op2; // Low XLEN bits

    // The whole pipe moves as one, frozen while the output waits
    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (avail) begin
            stage_valid[0] <= fu_packet.valid;
            for (int s = 1; s < `MULT_STAGES; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (avail) begin
            stage_prn[0]   <= fu_packet.dest_prn;
            stage_value[0] <= product;
            for (int s = 1; s < `MULT_STAGES; s++) begin
                stage_prn[s]   <= stage_prn[s-1];
                stage_value[s] <= stage_value[s-1];
            end
        end
    end

    assign result = '{
        valid:    stage_valid[LAST],
        dest_prn: stage_prn[LAST],
        value:    stage_value[LAST]
    };

endmodule

/* hw/psel_gen.sv */
module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    logic [WIDTH-1:0] remaining; // Requests not yet granted
    logic             found;

    // Grant r takes the lowest request left after grants 0..r-1
    always_comb begin
        remaining = req;
        found     = 1'b0;
        for (int r = 0; r < REQS; r++) begin
            gnt_bus[r] = '0;
            found      = 1'b0;
            for (int i = 0; i < WIDTH; i++) begin
                if (remaining[i] && !found) begin
                    gnt_bus[r][i] = 1'b1;
                    found         = 1'b1;
                end
            end
            remaining = remaining & ~gnt_bus[r];
        end
    end

endmodule

/* hw/rs.sv */
`include "rs_defines.svh"

module rs #(
    parameter int SIZE        = `RS_SZ,
    parameter int ALERT_DEPTH = `N
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  rs_pkg::rs_is_packet_t                 rs_is_packet,
    input  rs_pkg::cdb_packet_t [`N-1:0]          cdb,
    input  logic [`NUM_FU_ALU-1:0]                fu_alu_avail,
    input  logic [`NUM_FU_MULT-1:0]               fu_mult_avail,
    output rs_pkg::fu_packet_t [`NUM_FU_ALU-1:0]  fu_alu_packet,
    output rs_pkg::fu_packet_t [`NUM_FU_MULT-1:0] fu_mult_packet,
    output logic                                  almost_full
);

    localparam logic [`RS_CNT_WIDTH-1:0] ALERT_LEVEL = `RS_CNT_WIDTH'(SIZE - ALERT_DEPTH);
    localparam logic [`RS_CNT_WIDTH-1:0] ONE = `RS_CNT_WIDTH'(1);

    logic [`RS_CNT_WIDTH-1:0]      counter;
    logic [`RS_CNT_WIDTH-1:0]      next_counter;
    rs_pkg::rs_entry_t [SIZE-1:0]  entries;
    rs_pkg::rs_entry_t [SIZE-1:0]  next_entries;

    logic [SIZE-1:0] taken; // Claimed by a lane this cycle
    logic            placed;
    logic [SIZE-1:0] ready;
    logic [SIZE-1:0] alu_req;
    logic [SIZE-1:0] mult_req;

    logic [`NUM_FU_ALU-1:0][SIZE-1:0]  alu_gnt_bus;
    logic [`NUM_FU_MULT-1:0][SIZE-1:0] mult_gnt_bus;

    rs_pkg::fu_packet_t [`NUM_FU_ALU-1:0]  next_alu_packet;
    rs_pkg::fu_packet_t [`NUM_FU_MULT-1:0] next_mult_packet;

    function automatic rs_pkg::fu_packet_t to_packet(input rs_pkg::rs_entry_t entry);
        rs_pkg::fu_packet_t pkt;
        pkt.valid    = entry.valid;
        pkt.op       = entry.op;
        pkt.op1      = entry.op1;
        pkt.op2      = entry.op2;
        pkt.dest_prn = entry.dest_prn;
        return pkt;
    endfunction

    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            ready[i]    = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready;
            alu_req[i]  = ready[i] && (entries[i].fu == rs_pkg::FU_ALU);
            mult_req[i] = ready[i] && (entries[i].fu == rs_pkg::FU_MULT);
        end
    end

    psel_gen #(
        .WIDTH(SIZE),
        .REQS (`NUM_FU_ALU)
    ) alu_selector (
        .req    (alu_req),
        .gnt_bus(alu_gnt_bus)
    );

    psel_gen #(
        .WIDTH(SIZE),
        .REQS (`NUM_FU_MULT)
    ) mult_selector (
        .req    (mult_req),
        .gnt_bus(mult_gnt_bus)
    );

    always_comb begin
        next_entries     = entries;
        next_counter     = counter;
        next_alu_packet  = fu_alu_packet; // Held unless the unit is available
        next_mult_packet = fu_mult_packet;
        taken            = '0;
        placed           = 1'b0;

        // Lanes fill the lowest free entries in order
        for (int l = 0; l < `N; l++) begin
            placed = 1'b0;
            for (int i = 0; i < SIZE; i++) begin
                if (!almost_full && rs_is_packet.entries[l].valid && !placed &&
                    !entries[i].valid && !taken[i]) begin
                    next_entries[i] = rs_is_packet.entries[l];
                    taken[i]        = 1'b1;
                    placed          = 1'b1;
                    next_counter    = next_counter + ONE;
                end
            end
        end

        // Wakeup also covers entries written this cycle
        for (int i = 0; i < SIZE; i++) begin
            for (int s = 0; s < `N; s++) begin
                if (cdb[s].valid && cdb[s].dest_prn != '0) begin
                    if (!next_entries[i].op1_ready &&
                        next_entries[i].op1[`PRN_W-1:0] == cdb[s].dest_prn) begin
                        next_entries[i].op1_ready = 1'b1;
                        next_entries[i].op1       = cdb[s].value;
                    end
                    if (!next_entries[i].op2_ready &&
                        next_entries[i].op2[`PRN_W-1:0] == cdb[s].dest_prn) begin
                        next_entries[i].op2_ready = 1'b1;
                        next_entries[i].op2       = cdb[s].value;
                    end
                end
            end
        end

        for (int j = 0; j < `NUM_FU_ALU; j++) begin
            if (fu_alu_avail[j]) begin
                next_alu_packet[j] = '0;
                for (int i = 0; i < SIZE; i++) begin
                    if (alu_gnt_bus[j][i]) begin
                        next_alu_packet[j]    = to_packet(entries[i]);
                        next_entries[i].valid = 1'b0;
                        next_counter          = next_counter - ONE;
                    end
                end
            end
        end

        for (int j = 0; j < `NUM_FU_MULT; j++) begin
            if (fu_mult_avail[j]) begin
                next_mult_packet[j] = '0;
                for (int i = 0; i < SIZE; i++) begin
                    if (mult_gnt_bus[j][i]) begin
                        next_mult_packet[j]   = to_packet(entries[i]);
                        next_entries[i].valid = 1'b0;
                        next_counter          = next_counter - ONE;
                    end
                end
            end
        end
    end

    assign almost_full = counter > ALERT_LEVEL;

    always_ff @(posedge clock) begin
        if (reset) begin
            counter        <= '0;
            entries        <= '0;
            fu_alu_packet  <= '0;
            fu_mult_packet <= '0;
        end else begin
            counter        <= next_counter;
            entries        <= next_entries;
            fu_alu_packet  <= next_alu_packet;
            fu_mult_packet <= next_mult_packet;
        end
    end

endmodule

/* hw/rs_cluster.sv */
`include "rs_defines.svh"

module rs_cluster (
    input  logic                         clock,
    input  logic                         reset,
    input  rs_pkg::rs_is_packet_t        rs_is_packet,
    output logic                         almost_full,
    output rs_pkg::cdb_packet_t [`N-1:0] cdb
);

    rs_pkg::fu_packet_t [`NUM_FU_ALU-1:0]   fu_alu_packet;
    rs_pkg::fu_packet_t [`NUM_FU_MULT-1:0]  fu_mult_packet;
    rs_pkg::cdb_packet_t [`NUM_FU_ALU-1:0]  alu_result;
    rs_pkg::cdb_packet_t [`NUM_FU_MULT-1:0] mult_result;
    logic [`NUM_FU_ALU-1:0]                 fu_alu_avail;
    logic [`NUM_FU_MULT-1:0]                fu_mult_avail;

    rs #(
        .SIZE       (`RS_SZ),
        .ALERT_DEPTH(`N)
    ) rs_inst (
        .clock         (clock),
        .reset         (reset),
        .rs_is_packet  (rs_is_packet),
        .cdb           (cdb),
        .fu_alu_avail  (fu_alu_avail),
        .fu_mult_avail (fu_mult_avail),
        .fu_alu_packet (fu_alu_packet),
        .fu_mult_packet(fu_mult_packet),
        .almost_full   (almost_full)
    );

    for (genvar j = 0; j < `NUM_FU_ALU; j++) begin : alu_gen
        alu_fu alu_inst (
            .clock    (clock),
            .reset    (reset),
            .fu_packet(fu_alu_packet[j]),
            .avail    (fu_alu_avail[j]),
            .result   (alu_result[j])
        );
    end

    mult_fu mult_inst (
        .clock    (clock),
        .reset    (reset),
        .fu_packet(fu_mult_packet[0]),
        .avail    (fu_mult_avail[0]),
        .result   (mult_result[0])
    );

    cdb_arbiter cdb_arbiter_inst (
        .alu_result   (alu_result),
        .mult_result  (mult_result),
        .cdb          (cdb),
        .fu_alu_avail (fu_alu_avail),
        .fu_mult_avail(fu_mult_avail)
    );

endmodule

/* hw/rs_defines.svh */
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// Station geometry
`define RS_SZ 8
`define RS_CNT_WIDTH 4 // Must hold 0..RS_SZ

// Dispatch lanes, also the number of CDB slots
`define N 2

// Functional units
`define NUM_FU_ALU 2
`define NUM_FU_MULT 1

// Datapath
`define XLEN 32
`define PRN_W 6 // Tag 0 is reserved for no destination

// Multiplier latency in cycles
`define MULT_STAGES 3

`endif

/* hw/rs_pkg.sv */
`include "rs_defines.svh"

package rs_pkg;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_e;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5
    } alu_op_e;

    // Waiting operands keep their source tag in the low PRN_W bits
    typedef struct packed {
        logic               valid;
        fu_type_e           fu;
        alu_op_e            op;
        logic               op1_ready;
        logic [`XLEN-1:0]   op1;
        logic               op2_ready;
        logic [`XLEN-1:0]   op2;
        logic [`PRN_W-1:0]  dest_prn;
    } rs_entry_t;

    // One entry per dispatch lane, lane 0 oldest
    typedef struct packed {
        rs_entry_t [`N-1:0] entries;
    } rs_is_packet_t;

    typedef struct packed {
        logic               valid;
        alu_op_e            op;
        logic [`XLEN-1:0]   op1;
        logic [`XLEN-1:0]   op2;
        logic [`PRN_W-1:0]  dest_prn;
    } fu_packet_t;

    typedef struct packed {
        logic               valid;
        logic [`PRN_W-1:0]  dest_prn;
        logic [`XLEN-1:0]   value;
    } cdb_packet_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the rs_cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module rs_cluster_tb -f src.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vrs_cluster_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

/* src.f */
+incdir+hw
hw/rs_pkg.sv
hw/psel_gen.sv
hw/alu_fu.sv
hw/mult_fu.sv
hw/cdb_arbiter.sv
hw/rs.sv
hw/rs_cluster.sv
tb/rs_cluster_tb.sv

/* tb/rs_cluster_tb.sv */
`include "rs_defines.svh"

module rs_cluster_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TAGS        = 1 << `PRN_W;
    localparam int ALU_COUNT   = 20;
    localparam int CHAIN_COUNT = 10;
    localparam int MULT_COUNT  = 10;
    localparam int MIX_COUNT   = 60;
    localparam int ZERO_COUNT  = 7;
    localparam int TOTAL_COUNT = ALU_COUNT + CHAIN_COUNT + MULT_COUNT + MIX_COUNT + ZERO_COUNT;
    localparam int WATCHDOG_CYCLES = TOTAL_COUNT * 20 + 600;
    localparam int DRAIN_LIMIT = 100;

    logic                         clock = 1'b0;
    logic                         reset = 1'b1;
    rs_pkg::rs_is_packet_t        rs_is_packet = '0;
    logic                         almost_full;
    rs_pkg::cdb_packet_t [`N-1:0] cdb;

    integer seed = 32'h95cc6f68;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_start_errors;
    string  test_name = "reset";

    // Instruction list of the running test
    rs_pkg::alu_op_e   i_op   [TAGS];
    logic [`PRN_W-1:0] i_tag1 [TAGS];
    logic [`PRN_W-1:0] i_tag2 [TAGS];
    logic [`XLEN-1:0]  i_c1   [TAGS];
    logic [`XLEN-1:0]  i_c2   [TAGS];
    logic [`PRN_W-1:0] i_dest [TAGS];
    int                i_gap  [TAGS]; // Idle cycles before this dispatch
    int                n_instr;
    int                next_tag;

    // Expected value and sightings per tag
    logic [`XLEN-1:0] exp_val  [TAGS];
    bit               used     [TAGS];
    int               seen_cnt [TAGS];
    int               zero_expected;
    int               zero_seen;
    bit               full_seen; // almost_full observed high in this test

    rs_cluster rs_cluster_inst (
        .clock       (clock),
        .reset       (reset),
        .rs_is_packet(rs_is_packet),
        .almost_full (almost_full),
        .cdb         (cdb)
    );

    always #4 clock = ~clock;

    function automatic logic [`XLEN-1:0] ref_result(input rs_pkg::alu_op_e op,
                                                    input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b);
        case (op)
            rs_pkg::OP_ADD: return a + b;
            rs_pkg::OP_SUB: return a - b;
            rs_pkg::OP_AND: return a & b;
            rs_pkg::OP_OR:  return a | b;
            rs_pkg::OP_XOR: return a ^ b;
            rs_pkg::OP_MUL: return a * b; // Low half of the product
            default:        return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [`XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [`PRN_W-1:0] add_instr(input rs_pkg::alu_op_e op,
                                                    input logic [`PRN_W-1:0] tag1,
                                                    input logic [`XLEN-1:0] c1,
                                                    input logic [`PRN_W-1:0] tag2,
                                                    input logic [`XLEN-1:0] c2,
                                                    input int gap, input bit no_dest);
        logic [`XLEN-1:0]  a;
        logic [`PRN_W-1:0] dest;
        logic [`XLEN-1:0]  b;
        a = (tag1 != '0) ? exp_val[tag1] : c1;
        b = (tag2 != '0) ? exp_val[tag2] : c2;
        dest = '0;
        if (no_dest) begin
            zero_expected++;
        end else begin
            dest = `PRN_W'(next_tag);
            next_tag++;
            used[dest]    = 1'b1;
            exp_val[dest] = ref_result(op, a, b);
        end
        i_op[n_instr]   = op;
        i_tag1[n_instr] = tag1;
        i_tag2[n_instr] = tag2;
        i_c1[n_instr]   = c1;
        i_c2[n_instr]   = c2;
        i_dest[n_instr] = dest;
        i_gap[n_instr]  = gap;
        n_instr++;
        return dest;
    endfunction

    // Picks one of the last eight tags when use_tag is set
    function automatic logic [`PRN_W-1:0] pick_source(input logic use_tag, input logic [2:0] back);
        int cand;
        if (!use_tag || next_tag <= 1) return '0;
        cand = next_tag - 1 - int'(back);
        if (cand < 1) cand = 1;
        return `PRN_W'(cand);
    endfunction

    // Already broadcast means the value is sent as ready
    function automatic logic [`XLEN:0] operand_field(input logic [`PRN_W-1:0] tag,
                                                     input logic [`XLEN-1:0] c);
        if (tag == '0) return {1'b1, c};
        if (seen_cnt[tag] > 0) return {1'b1, exp_val[tag]};
        return {1'b0, `XLEN'(tag)};
    endfunction

    function automatic rs_pkg::rs_entry_t make_entry(input int k);
        rs_pkg::rs_entry_t e;
        logic [`XLEN:0]    f1;
        logic [`XLEN:0]    f2;
        f1          = operand_field(i_tag1[k], i_c1[k]);
        f2          = operand_field(i_tag2[k], i_c2[k]);
        e           = '0;
        e.valid     = 1'b1;
        e.fu        = (i_op[k] == rs_pkg::OP_MUL) ? rs_pkg::FU_MULT : rs_pkg::FU_ALU;
        e.op        = i_op[k];
        e.op1_ready = f1[`XLEN];
        e.op1       = f1[`XLEN-1:0];
        e.op2_ready = f2[`XLEN];
        e.op2       = f2[`XLEN-1:0];
        e.dest_prn  = i_dest[k];
        return e;
    endfunction

    function automatic rs_pkg::rs_is_packet_t make_packet(input int k, input bit pair);
        rs_pkg::rs_is_packet_t p;
        p = '0;
        p.entries[0] = make_entry(k);
        if (pair) p.entries[1] = make_entry(k + 1);
        return p;
    endfunction

    function automatic bit all_seen();
        for (int t = 1; t < TAGS; t++) begin
            if (used[t] && seen_cnt[t] == 0) return 1'b0;
        end
        return zero_seen >= zero_expected;
    endfunction

    // Repeats a group until it is presented while almost_full is low
    task automatic run_dispatch();
        int k;
        bit pair;
        bit accepted;
        k = 0;
        while (k < n_instr) begin
            pair = (k + 1 < n_instr) && (i_gap[k + 1] == 0);
            repeat (i_gap[k]) begin
                @(posedge clock);
                rs_is_packet <= '0;
            end
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clock);
                rs_is_packet <= make_packet(k, pair);
                @(negedge clock);
                accepted = !almost_full;
            end
            k += pair ? 2 : 1;
        end
        @(posedge clock);
        rs_is_packet <= '0;
    endtask

    task automatic start_test(input string name);
        @(posedge clock);
        test_name = name;
        for (int t = 0; t < TAGS; t++) begin
            used[t]     = 1'b0;
            seen_cnt[t] = 0;
            exp_val[t]  = '0;
        end
        n_instr           = 0;
        next_tag          = 1;
        zero_expected     = 0;
        zero_seen         = 0;
        full_seen         = 1'b0;
        test_start_errors = errors;
    endtask

    task automatic finish_test(input bit expect_full);
        int cycles;
        run_dispatch();
        cycles = 0;
        while (!all_seen() && cycles < DRAIN_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        repeat (10) @(posedge clock); // Window for late duplicates
        for (int t = 1; t < TAGS; t++) begin
            if (used[t] && seen_cnt[t] == 0) begin
                errors++;
                $display("%s: tag %0d never appeared on the CDB", test_name, t);
            end else if (seen_cnt[t] > 1) begin
                errors++;
                $display("%s: tag %0d appeared %0d times on the CDB", test_name, t, seen_cnt[t]);
            end
        end
        check_value({test_name, " dest-zero results"}, 32'(zero_expected), 32'(zero_seen));
        if (expect_full && !full_seen) begin
            errors++;
            $display("%s: almost_full never went high", test_name);
        end
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    // Scoreboard on the CDB
    always @(negedge clock) begin
        logic [`PRN_W-1:0] tag;
        if (!reset) begin
            if (almost_full) begin
                full_seen = 1'b1;
            end
            for (int s = 0; s < `N; s++) begin
                if (cdb[s].valid) begin
                    tag = cdb[s].dest_prn;
                    if (tag == '0) begin
                        zero_seen++;
                    end else if (!used[tag]) begin
                        errors++;
                        $display("%s: result for unexpected tag %0d", test_name, tag);
                    end else begin
                        seen_cnt[tag]++;
                        check_value($sformatf("%s tag %0d", test_name, tag), exp_val[tag],
                                    cdb[s].value);
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rs_pkg::alu_op_e   op;
        logic [`PRN_W-1:0] t;
        logic [`PRN_W-1:0] m;
        logic [`PRN_W-1:0] c;
        logic [`PRN_W-1:0] mt [6];
        logic [`XLEN-1:0]  r;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        start_test("reset_idle");
        repeat (8) begin
            @(negedge clock);
            check_value("reset_idle almost_full", '0, 32'(almost_full));
            for (int s = 0; s < `N; s++) begin
                check_value("reset_idle cdb valid", '0, 32'(cdb[s].valid));
            end
        end
        finish_test(1'b0);

        start_test("alu_ops");
        for (int i = 0; i < ALU_COUNT; i++) begin
            op = rs_pkg::alu_op_e'(3'(i % 5));
            void'(add_instr(op, '0, rand_word(), '0, rand_word(), 0, 1'b0));
        end
        finish_test(1'b0);

        // Gap 5 puts each XOR dispatch in the cycle its producer broadcasts
        start_test("dependency_chains");
        t = add_instr(rs_pkg::OP_ADD, '0, rand_word(), '0, rand_word(), 0, 1'b0);
        t = add_instr(rs_pkg::OP_SUB, t, '0, '0, rand_word(), 0, 1'b0);
        repeat (4) begin
            t = add_instr(rs_pkg::OP_XOR, t, '0, t, '0, 5, 1'b0); // Both sources one tag
            t = add_instr(rs_pkg::OP_OR, t, '0, '0, rand_word(), 0, 1'b0);
        end
        finish_test(1'b0);

        start_test("mult_pipeline");
        for (int i = 0; i < 6; i++) begin
            mt[i] = add_instr(rs_pkg::OP_MUL, '0, rand_word(), '0, rand_word(), 0, 1'b0);
        end
        t = add_instr(rs_pkg::OP_ADD, mt[0], '0, mt[1], '0, 0, 1'b0);
        t = add_instr(rs_pkg::OP_MUL, mt[2], '0, t, '0, 0, 1'b0);
        c = add_instr(rs_pkg::OP_SUB, mt[5], '0, '0, rand_word(), 0, 1'b0);
        void'(add_instr(rs_pkg::OP_XOR, c, '0, mt[3], '0, 0, 1'b0));
        finish_test(1'b0);

        start_test("mixed_stream");
        for (int i = 0; i < MIX_COUNT; i++) begin
            r  = rand_word();
            op = rs_pkg::alu_op_e'(3'(r % 6));
            void'(add_instr(op, pick_source(r[8], r[12:10]), rand_word(),
                            pick_source(r[9], r[15:13]), rand_word(), 0, 1'b0));
        end
        finish_test(1'b1);

        start_test("tag_zero");
        m = add_instr(rs_pkg::OP_MUL, '0, rand_word(), '0, rand_word(), 0, 1'b0);
        void'(add_instr(rs_pkg::OP_ADD, '0, rand_word(), '0, rand_word(), 0, 1'b1));
        void'(add_instr(rs_pkg::OP_XOR, '0, rand_word(), '0, rand_word(), 0, 1'b1));
        c = add_instr(rs_pkg::OP_ADD, m, '0, '0, rand_word(), 0, 1'b0);
        void'(add_instr(rs_pkg::OP_AND, '0, rand_word(), '0, rand_word(), 0, 1'b1));
        void'(add_instr(rs_pkg::OP_OR, m, '0, '0, rand_word(), 0, 1'b1));
        void'(add_instr(rs_pkg::OP_SUB, c, '0, m, '0, 0, 1'b0));
        finish_test(1'b0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
